// ==== all.f ====
+incdir+hw
hw/soc_bus_pkg.sv
hw/soc_map_pkg.sv
hw/soc_addr_decoder.sv
hw/soc_spm_target.sv
hw/soc_rsp_mux.sv
hw/dbg_req_gate.sv
hw/soc_subsystem.sv
bench/tb_soc_subsystem.sv

// ==== bench/tb_soc_subsystem.sv ====
/*
 * Self-checking testbench for the scratchpad interconnect.
 * Checks the debug hold-off, then runs a stimulus table and random
 * transactions against a byte-lane reference memory.
 */

`timescale 1ns/100ps

`include "soc_bus_cfg.svh"

module tb_soc_subsystem;

  import soc_bus_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_STIM   = 19;
  localparam int RAND_TXNS  = 32;
  localparam int WDOG_CYCLES = (NUM_STIM + RAND_TXNS) * 4 + `SOC_DBG_DELAY + 20;

  typedef struct packed {
    logic                   we;
    logic [`SOC_ADDR_W-1:0] adr;
    logic [`SOC_DATA_W-1:0] dat;
    logic [`SOC_SEL_W-1:0]  sel;
    logic                   exp_err;
  } stim_t;

  logic    clk_i = 1'b0;
  logic    ndmreset_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    dbg_req_i;
  logic    dbg_req_o;

  stim_t                  stim_tbl [NUM_STIM];
  logic [`SOC_DATA_W-1:0] ref_mem [`SOC_NUM_TGT][`SOC_SPM_WORDS];
  logic [`SOC_SEL_W-1:0]  ref_known [`SOC_NUM_TGT][`SOC_SPM_WORDS];
  logic [31:0]            rnd_state = 32'h4dfe;
  logic [`SOC_ADDR_W-1:0] rnd_addr [RAND_TXNS/2];

  soc_subsystem u_dut (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .wb_req_i   ( wb_req     ),
    .wb_rsp_o   ( wb_rsp     ),
    .dbg_req_i  ( dbg_req_i  ),
    .dbg_req_o  ( dbg_req_o  )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopping at first mismatch");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic stim_t make_stim(input logic we, input logic [31:0] adr,
                                      input logic [31:0] dat, input logic [3:0] sel,
                                      input logic exp_err);
    stim_t s;
    s.we      = we;
    s.adr     = adr;
    s.dat     = dat;
    s.sel     = sel;
    s.exp_err = exp_err;
    return s;
  endfunction

  // Offset 5 in every region, then partial writes, then misses
  task automatic load_stim_table();
    stim_tbl[0]  = make_stim(1'b1, 32'h1000_0014, 32'ha0a0_0001, 4'hf, 1'b0);
    stim_tbl[1]  = make_stim(1'b1, 32'h1000_0114, 32'hb1b1_0002, 4'hf, 1'b0);
    stim_tbl[2]  = make_stim(1'b1, 32'h1000_0214, 32'hc2c2_0003, 4'hf, 1'b0);
    stim_tbl[3]  = make_stim(1'b1, 32'h1000_0314, 32'hd3d3_0004, 4'hf, 1'b0);
    stim_tbl[4]  = make_stim(1'b0, 32'h1000_0014, 32'h0, 4'hf, 1'b0);
    stim_tbl[5]  = make_stim(1'b0, 32'h1000_0114, 32'h0, 4'hf, 1'b0);
    stim_tbl[6]  = make_stim(1'b0, 32'h1000_0214, 32'h0, 4'hf, 1'b0);
    stim_tbl[7]  = make_stim(1'b0, 32'h1000_0314, 32'h0, 4'hf, 1'b0);
    stim_tbl[8]  = make_stim(1'b1, 32'h1000_0114, 32'h5566_7788, 4'b0101, 1'b0);
    stim_tbl[9]  = make_stim(1'b0, 32'h1000_0114, 32'h0, 4'hf, 1'b0);
    stim_tbl[10] = make_stim(1'b1, 32'h1000_03fc, 32'hffff_0000, 4'hf, 1'b0);
    stim_tbl[11] = make_stim(1'b1, 32'h1000_03fc, 32'h1234_5678, 4'b0110, 1'b0);
    stim_tbl[12] = make_stim(1'b0, 32'h1000_03fc, 32'h0, 4'hf, 1'b0);
    // Wrong tag and out-of-range regions alias offset 5 of the map
    stim_tbl[13] = make_stim(1'b1, 32'h2000_0014, 32'hdead_beef, 4'hf, 1'b1);
    stim_tbl[14] = make_stim(1'b1, 32'h1000_0414, 32'hdead_beef, 4'hf, 1'b1);
    stim_tbl[15] = make_stim(1'b0, 32'h1000_ff00, 32'h0, 4'hf, 1'b1);
    stim_tbl[16] = make_stim(1'b0, 32'h1000_0014, 32'h0, 4'hf, 1'b0);
    stim_tbl[17] = make_stim(1'b0, 32'h1000_0114, 32'h0, 4'hf, 1'b0);
    stim_tbl[18] = make_stim(1'b0, 32'h1000_0314, 32'h0, 4'hf, 1'b0);
  endtask

  // ------------------------------
  // One Wishbone classic transaction
  // ------------------------------
  // Called 1 ns after a rising edge; returns at the same phase
  task automatic run_bus_txn(input logic we, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel,
                             input logic exp_err);
    int unsigned rg;
    int unsigned ofs;
    logic [31:0] mask;
    rg  = adr[15:8];
    ofs = adr[7:2];
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    @(posedge clk_i);
    #1;
    if (exp_err) begin
      assert (wb_rsp.err === 1'b1 && wb_rsp.ack === 1'b0 && wb_rsp.dat === '0)
        else report_error($sformatf("no clean error response at %h", adr));
    end else begin
      assert (wb_rsp.ack === 1'b1 && wb_rsp.err === 1'b0)
        else report_error($sformatf("missing ack at %h", adr));
      if (we) begin
        for (int b = 0; b < `SOC_SEL_W; b++) begin
          if (sel[b]) begin
            ref_mem[rg][ofs][b*8 +: 8] = dat[b*8 +: 8];
            ref_known[rg][ofs][b] = 1'b1;
          end
        end
      end else begin
        // Bytes never written hold no defined value
        for (int b = 0; b < `SOC_SEL_W; b++) begin
          mask[b*8 +: 8] = {8{ref_known[rg][ofs][b]}};
        end
        assert ((wb_rsp.dat & mask) === (ref_mem[rg][ofs] & mask))
          else report_error($sformatf("read %h got %h expected %h", adr,
                                      wb_rsp.dat, ref_mem[rg][ofs]));
      end
    end
    // Request still held through the ack cycle
    @(posedge clk_i);
    #1;
    assert (wb_rsp.ack === 1'b0 && wb_rsp.err === 1'b0)
      else report_error($sformatf("response longer than one cycle at %h", adr));
    wb_req = '0;
    // One idle cycle before the next request
    @(posedge clk_i);
    #1;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    logic [31:0] data;
    logic [3:0]  sel;
    ndmreset_n = 1'b0;
    dbg_req_i  = 1'b1;
    wb_req     = '0;
    for (int r = 0; r < `SOC_NUM_TGT; r++) begin
      for (int w = 0; w < `SOC_SPM_WORDS; w++) begin
        ref_known[r][w] = '0;
      end
    end
    load_stim_table();

    repeat (8) @(posedge clk_i);
    #1;
    assert (wb_rsp.ack === 1'b0 && wb_rsp.err === 1'b0 && dbg_req_o === 1'b0)
      else report_error("outputs not low in reset");
    ndmreset_n = 1'b1;

    // Debug hold-off, dbg_req_i high since reset
    assert (dbg_req_o === 1'b0) else report_error("debug request passed at release");
    for (int k = 1; k <= `SOC_DBG_DELAY; k++) begin
      @(posedge clk_i);
      #1;
      if (k < `SOC_DBG_DELAY) begin
        assert (dbg_req_o === 1'b0)
          else report_error($sformatf("debug request passed after %0d edges", k));
      end else begin
        assert (dbg_req_o === 1'b1) else report_error("debug request still masked");
      end
    end
    dbg_req_i = 1'b0;
    @(posedge clk_i);
    #1;
    assert (dbg_req_o === 1'b0) else report_error("debug request did not follow low");
    dbg_req_i = 1'b1;
    @(posedge clk_i);
    #1;
    assert (dbg_req_o === 1'b1) else report_error("debug request did not follow high");
    dbg_req_i = 1'b0;

    for (int n = 0; n < NUM_STIM; n++) begin
      run_bus_txn(stim_tbl[n].we, stim_tbl[n].adr, stim_tbl[n].dat,
                  stim_tbl[n].sel, stim_tbl[n].exp_err);
    end

    // Random writes first, then reads of the same words
    for (int n = 0; n < RAND_TXNS / 2; n++) begin
      rnd_state = xorshift32(rnd_state);
      rnd_addr[n] = (`SOC_MAP_TAG << 16) | ((rnd_state % `SOC_NUM_TGT) << 8)
                  | (((rnd_state >> 8) % `SOC_SPM_WORDS) << 2);
      rnd_state = xorshift32(rnd_state);
      data = rnd_state;
      rnd_state = xorshift32(rnd_state);
      sel = (rnd_state[3:0] == 4'h0) ? 4'hf : rnd_state[3:0];
      run_bus_txn(1'b1, rnd_addr[n], data, sel, 1'b0);
    end
    for (int n = 0; n < RAND_TXNS / 2; n++) begin
      run_bus_txn(1'b0, rnd_addr[n], 32'h0, 4'hf, 1'b0);
    end

    $display("Verification passed");
    $finish;
  end

  // Watchdog sized from the number of transactions
  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: tests did not complete within %0d cycles", WDOG_CYCLES);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== hw/dbg_req_gate.sv ====
/*
 * Masks the debug request for a fixed number of cycles after reset,
 * so early boot code runs before a halt can be requested.
 * After the window the request passes through unchanged.
 */

`timescale 1ns/100ps

`include "soc_bus_cfg.svh"

module dbg_req_gate (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic dbg_req_i,
  output logic dbg_req_o
);

  localparam int unsigned CntW = $clog2(`SOC_DBG_DELAY + 1);

  logic [CntW-1:0] cnt_q;

  // ------------------------------
  // Hold-off counter
  // ------------------------------
  // Loads the window in reset, parks at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CntW'(`SOC_DBG_DELAY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Window closed, request goes straight through
  assign dbg_req_o = (cnt_q == '0) ? dbg_req_i : 1'b0;

endmodule

// ==== hw/soc_addr_decoder.sv ====
/*
 * Address map decoder for the scratchpad regions.
 * Purely combinational: a valid request either selects exactly one
 * region or raises miss for the error path in the response mux.
 */

`timescale 1ns/100ps

`include "soc_bus_cfg.svh"

module soc_addr_decoder (
  input  soc_bus_pkg::wb_req_t  req_i,
  output soc_map_pkg::tgt_sel_t tgt_sel_o,
  output logic                  miss_o
);

  import soc_map_pkg::*;

  soc_addr_u addr;
  logic      req_vld;
  logic      tag_ok;
  logic      region_ok;

  assign addr.raw = req_i.adr;

  // Classic cycle, request valid while both strobes high
  assign req_vld = req_i.cyc & req_i.stb;

  // ------------------------------
  // Map lookup
  // ------------------------------
  assign tag_ok    = (addr.f.tag == `SOC_MAP_TAG);
  assign region_ok = (addr.f.region < `SOC_NUM_TGT);

  always_comb begin
    tgt_sel_o = '0;
    for (int i = 0; i < `SOC_NUM_TGT; i++) begin
      if (req_vld && tag_ok && (addr.f.region == i)) begin
        tgt_sel_o[i] = 1'b1;
      end
    end
  end

  // Wrong tag or region past the last scratchpad
  assign miss_o = req_vld & ~(tag_ok & region_ok);

  // ------------------------------
  // Checks
  // ------------------------------
  // At most one route per request, target or error
  a_one_route: assert final ($onehot0({tgt_sel_o, miss_o}));

endmodule

// ==== hw/soc_bus_cfg.svh ====
/*
 * Build-time configuration of the scratchpad interconnect.
 * Widths, region count, region depth, address map tag and the
 * debug hold-off after reset. Included by every RTL file.
 */

`ifndef SOC_BUS_CFG_SVH
`define SOC_BUS_CFG_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_SEL_W (`SOC_DATA_W / 8)

// ------------------------------
// Address map
// ------------------------------
// Number of identical scratchpad regions
`define SOC_NUM_TGT 4
// Words per region, offset field sits at address bits 7:2
`define SOC_SPM_WORDS 64
// Required value of address bits 31:16
`define SOC_MAP_TAG 16'h1000

// ------------------------------
// Debug
// ------------------------------
// Cycles after reset release before a debug request may pass
`define SOC_DBG_DELAY 50

`endif

// ==== hw/soc_bus_pkg.sv ====
/*
 * Wishbone classic request and response types.
 * One request travels from the master to every target, and each
 * target answers with its own response word.
 */

`include "soc_bus_cfg.svh"

package soc_bus_pkg;

  // ------------------------------
  // Master to target
  // ------------------------------
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`SOC_ADDR_W-1:0] adr;
    logic [`SOC_DATA_W-1:0] dat;
    // One bit per data byte
    logic [`SOC_SEL_W-1:0]  sel;
  } wb_req_t;

  // ------------------------------
  // Target to master
  // ------------------------------
  typedef struct packed {
    logic                   ack;
    logic                   err;
    // Read data, valid with ack
    logic [`SOC_DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage

// ==== hw/soc_map_pkg.sv ====
/*
 * Address map types shared by the decoder, the targets and the mux.
 * The address word is seen either raw or split into its map fields;
 * the target select is one bit per scratchpad region.
 */

`include "soc_bus_cfg.svh"

package soc_map_pkg;

  // ------------------------------
  // Address layout
  // ------------------------------
  // Bits 31:16 tag, 15:8 region, 7:2 word offset, 1:0 byte lane
  typedef struct packed {
    logic [15:0]                      tag;
    logic [7:0]                       region;
    logic [$clog2(`SOC_SPM_WORDS)-1:0] offset;
    logic [1:0]                       byte_ofs;
  } soc_addr_fields_t;

  // Decoder reads tag and region, targets read the offset
  typedef union packed {
    logic [`SOC_ADDR_W-1:0] raw;
    soc_addr_fields_t       f;
  } soc_addr_u;

  // ------------------------------
  // Target select
  // ------------------------------
  // At most one bit set, none on a miss
  typedef logic [`SOC_NUM_TGT-1:0] tgt_sel_t;

endpackage

// ==== hw/soc_rsp_mux.sv ====
/*
 * Response path from the scratchpad regions back to the master.
 * Ack and data of the region that was addressed pass straight through;
 * a decode miss is answered here with a one-cycle error.
 */

`timescale 1ns/100ps

`include "soc_bus_cfg.svh"

module soc_rsp_mux (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  soc_bus_pkg::wb_rsp_t tgt_rsp_i [`SOC_NUM_TGT],
  input  soc_map_pkg::tgt_sel_t tgt_sel_i,
  input  logic                 miss_i,
  output soc_bus_pkg::wb_rsp_t rsp_o
);

  import soc_map_pkg::*;

  tgt_sel_t               sel_q;
  logic [`SOC_NUM_TGT-1:0] tgt_ack;
  logic                   err_q;

  // ------------------------------
  // Route and error state
  // ------------------------------
  // Select of the request cycle, lines up with the target ack
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      sel_q <= '0;
      err_q <= 1'b0;
    end else begin
      sel_q <= tgt_sel_i;
      err_q <= miss_i & ~err_q;
    end
  end

  always_comb begin
    for (int i = 0; i < `SOC_NUM_TGT; i++) begin
      tgt_ack[i] = tgt_rsp_i[i].ack;
    end
  end

  // ------------------------------
  // Output merge
  // ------------------------------
  always_comb begin
    rsp_o = '0;
    for (int i = 0; i < `SOC_NUM_TGT; i++) begin
      if (sel_q[i]) begin
        rsp_o.ack = tgt_ack[i];
        rsp_o.dat = tgt_rsp_i[i].dat;
      end
    end
    // Data stays zero on an error, no region selected
    rsp_o.err = err_q;
  end

  // Regions never answer together
  a_single_ack: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $onehot0(tgt_ack));

endmodule

// ==== hw/soc_spm_target.sv ====
/*
 * One scratchpad region on the Wishbone bus.
 * Writes honour the byte selects, reads return the addressed word.
 * Every selected request gets a single registered ack one cycle later.
 */

`timescale 1ns/100ps

`include "soc_bus_cfg.svh"

module soc_spm_target (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  soc_bus_pkg::wb_req_t req_i,
  input  logic                 sel_i,
  output soc_bus_pkg::wb_rsp_t rsp_o
);

  import soc_map_pkg::*;

  logic [`SOC_DATA_W-1:0] mem_q [`SOC_SPM_WORDS];
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   ack_q;
  logic                   access;
  soc_addr_u              addr;

  assign addr.raw = req_i.adr;

  // No new access in the ack cycle, one pulse per transaction
  assign access = req_i.cyc & req_i.stb & sel_i & ~ack_q;

  // ------------------------------
  // Acknowledge
  // ------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (access && req_i.we) begin
      for (int b = 0; b < `SOC_SEL_W; b++) begin
        // Only the selected byte lanes change
        if (req_i.sel[b]) begin
          mem_q[addr.f.offset][b*8 +: 8] <= req_i.dat[b*8 +: 8];
        end
      end
    end
    if (access && !req_i.we) begin
      rdata_q <= mem_q[addr.f.offset];
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rdata_q};

  // ------------------------------
  // Checks
  // ------------------------------
  // An ack needs a selected strobe on the previous edge
  a_ack_cause: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    ack_q |-> $past(req_i.cyc && req_i.stb && sel_i));

endmodule

// ==== hw/soc_subsystem.sv ====
/*
 * Scratchpad interconnect top level.
 * One Wishbone master reaches SOC_NUM_TGT scratchpad regions through
 * the address decoder; unmapped addresses return an error.
 */

`timescale 1ns/100ps

`include "soc_bus_cfg.svh"

module soc_subsystem (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  soc_bus_pkg::wb_req_t wb_req_i,
  output soc_bus_pkg::wb_rsp_t wb_rsp_o,
  input  logic                 dbg_req_i,
  output logic                 dbg_req_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  tgt_sel_t tgt_sel;
  logic     miss;
  wb_rsp_t  tgt_rsp [`SOC_NUM_TGT];

  // ------------------------------
  // Address decode
  // ------------------------------
  soc_addr_decoder u_decoder (
    .req_i     ( wb_req_i ),
    .tgt_sel_o ( tgt_sel  ),
    .miss_o    ( miss     )
  );

  // ------------------------------
  // Scratchpad regions
  // ------------------------------
  for (genvar i = 0; i < `SOC_NUM_TGT; i++) begin : g_tgt
    soc_spm_target u_spm (
      .clk_i      ( clk_i      ),
      .ndmreset_n ( ndmreset_n ),
      .req_i      ( wb_req_i   ),
      .sel_i      ( tgt_sel[i] ),
      .rsp_o      ( tgt_rsp[i] )
    );
  end

  // Back to the master, errors for misses
  soc_rsp_mux u_rsp_mux (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .tgt_rsp_i  ( tgt_rsp    ),
    .tgt_sel_i  ( tgt_sel    ),
    .miss_i     ( miss       ),
    .rsp_o      ( wb_rsp_o   )
  );

  // ------------------------------
  // Debug request hold-off
  // ------------------------------
  dbg_req_gate u_dbg_gate (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .dbg_req_i  ( dbg_req_i  ),
    .dbg_req_o  ( dbg_req_o  )
  );

endmodule
